//--- hw/pdp_pkg.sv
/*
   Shared widths and I/O-page addresses for the PDP-11 memory subsystem.
   Imported by every RTL module and by the testbench.
*/
package pdp_pkg;

   // ------------------------------
   // widths
   localparam int va_w   = 16;
   localparam int pa_w   = 18;
   localparam int par_w  = 12;
   localparam int word_w = 16;

   // ------------------------------
   // page arithmetic
   // one par unit is a 64-byte block, pages are 8 KB
   localparam int blk_shift  = 6;
   localparam int page_off_w = 13;

   // kernel page 7 falls on the I/O page when the MMU is off
   localparam logic [va_w-1:0] unmapped_va    = 16'o160000;
   localparam logic [pa_w-1:0] unmapped_reloc = 18'o600000;

   // ------------------------------
   // I/O-page addresses
   localparam logic [pa_w-1:0] iopage_base = 18'o760000;
   localparam logic [pa_w-1:0] par_base    = 18'o772340;
   localparam logic [pa_w-1:0] mmr0_addr   = 18'o777572;
   localparam logic [pa_w-1:0] swr_addr    = 18'o777570;

endpackage

//--- hw/reset_btn.sv
/*
   Reset push-button debouncer. Produces a soft reset that stays high
   while the button is held, once it has been held long enough.
*/
module reset_btn #(
   parameter int debounce_cycles = 16
) (
   input  logic sysclk,
   input  logic rst_n,
   input  logic button,
   output logic soft_reset
);

   localparam int cnt_w = $clog2(debounce_cycles + 1);

   logic [cnt_w-1:0] cnt;

   // consecutive cycles of button high, saturating
   always_ff @(posedge sysclk)
   begin
      if (!rst_n)
         cnt <= '0;
      else if (!button)
         cnt <= '0;
      else if (cnt != cnt_w'(debounce_cycles))
         cnt <= cnt + 1'b1;
   end

   assign soft_reset = (cnt == cnt_w'(debounce_cycles));

endmodule

//--- hw/mmu.sv
/*
   Kernel-mode memory management: eight page address registers plus the
   enable bit, and the virtual-to-physical translation used by the bus.
   Registers are reached through the pxr port, index 8 is the enable.
*/
module mmu
   import pdp_pkg::*;
(
   input  logic              sysclk,
   input  logic              rst_n,
   input  logic              soft_reset,
   input  logic [va_w-1:0]   cpu_va,
   output logic [pa_w-1:0]   cpu_pa,
   input  logic              pxr_wr,
   input  logic              pxr_rd,
   input  logic [3:0]        pxr_addr,
   input  logic [word_w-1:0] pxr_data_in,
   output logic [word_w-1:0] pxr_data_out
);

   logic [par_w-1:0] par_q [0:7];
   logic             enable_q;
   logic [2:0]       page;
   logic [pa_w-1:0]  pa_mapped;
   logic [pa_w-1:0]  pa_unmapped;

   // ------------------------------
   // register file
   always_ff @(posedge sysclk)
   begin
      if (!rst_n || soft_reset)
      begin
         enable_q <= 1'b0;
         for (int i = 0; i < 8; i++)
         begin
            par_q[i] <= '0;
         end
      end
      else if (pxr_wr)
      begin
         if (pxr_addr == 4'd8)
            enable_q <= pxr_data_in[0];
         else
            par_q[pxr_addr[2:0]] <= pxr_data_in[par_w-1:0];
      end
   end

   always_comb
   begin
      pxr_data_out = '0;
      if (pxr_rd)
      begin
         if (pxr_addr == 4'd8)
            pxr_data_out = word_w'(enable_q);
         else
            pxr_data_out = word_w'(par_q[pxr_addr[2:0]]);
      end
   end

   // ------------------------------
   // translation
   assign page = cpu_va[va_w-1:page_off_w];

   // block base plus offset in page, wraps at 256 KB
   assign pa_mapped = (pa_w'(par_q[page]) << blk_shift) + pa_w'(cpu_va[page_off_w-1:0]);

   assign pa_unmapped = (cpu_va >= unmapped_va) ? pa_w'(cpu_va) + unmapped_reloc
                                                : pa_w'(cpu_va);

   assign cpu_pa = enable_q ? pa_mapped : pa_unmapped;

endmodule

//--- hw/bus.sv
/*
   Physical bus: decodes RAM, MMU registers and the switch/display
   register, steers byte lanes and answers the processor handshake.
   Register and error replies take one cycle, RAM replies take two.
*/
module bus
   import pdp_pkg::*;
#(
   parameter int ram_words = 4096
) (
   input  logic                         sysclk,
   input  logic                         rst_n,
   input  logic                         soft_reset,
   input  logic [pa_w-1:0]              cpu_pa,
   input  logic [word_w-1:0]            bus_data_in,
   output logic [word_w-1:0]            bus_data_out,
   input  logic                         bus_rd,
   input  logic                         bus_wr,
   input  logic                         bus_byte_op,
   output logic                         bus_ack,
   output logic                         bus_error,
   input  logic [word_w-1:0]            switches,
   output logic                         pxr_wr,
   output logic                         pxr_rd,
   output logic [3:0]                   pxr_addr,
   output logic [word_w-1:0]            pxr_data_in,
   input  logic [word_w-1:0]            pxr_data_out,
   output logic [$clog2(ram_words)-1:0] ram_addr,
   output logic [word_w-1:0]            ram_wdata,
   output logic [1:0]                   ram_be,
   output logic                         ram_we,
   input  logic [word_w-1:0]            ram_rdata,
   output logic [word_w-1:0]            disp_value
);

   localparam int ram_aw = $clog2(ram_words);
   localparam logic [pa_w-1:0] ram_top = pa_w'(ram_words * 2);

   typedef enum logic [1:0] {st_idle, st_ram_wait, st_respond, st_done} state_t;

   state_t            state;
   logic              strobe;
   logic              go;
   logic              odd_word;
   logic              io_sel;
   logic              ram_hit;
   logic              par_hit;
   logic              mmr0_hit;
   logic              swr_hit;
   logic              reg_hit;
   logic [1:0]        be;
   logic [word_w-1:0] wdata_lane;
   logic [word_w-1:0] reg_word;
   logic              err_q;
   logic              ram_src_q;
   logic              is_byte_q;
   logic              odd_q;
   logic [word_w-1:0] rdata_q;
   logic [word_w-1:0] disp_q;

   // byte reads come back in the low lane, zero above
   function automatic logic [word_w-1:0] steer_rd(input logic [word_w-1:0] w,
                                                  input logic is_byte,
                                                  input logic odd);
      if (!is_byte)
         return w;
      return odd ? {8'h00, w[15:8]} : {8'h00, w[7:0]};
   endfunction

   // ------------------------------
   // decode
   assign strobe   = bus_rd | bus_wr;
   assign go       = (state == st_idle) && strobe;
   assign odd_word = !bus_byte_op && cpu_pa[0];
   assign io_sel   = (cpu_pa >= iopage_base);
   assign ram_hit  = (cpu_pa < ram_top) && !odd_word;
   assign par_hit  = io_sel && (cpu_pa[pa_w-1:4] == par_base[pa_w-1:4]) && !odd_word;
   assign mmr0_hit = io_sel && (cpu_pa[pa_w-1:1] == mmr0_addr[pa_w-1:1]) && !odd_word;
   assign swr_hit  = io_sel && (cpu_pa[pa_w-1:1] == swr_addr[pa_w-1:1]) && !odd_word;
   assign reg_hit  = par_hit | mmr0_hit | swr_hit;

   assign be = bus_byte_op ? (cpu_pa[0] ? 2'b10 : 2'b01) : 2'b11;
   assign wdata_lane = !bus_byte_op ? bus_data_in :
                       cpu_pa[0]    ? {bus_data_in[7:0], 8'h00} :
                                      {8'h00, bus_data_in[7:0]};

   assign pxr_rd      = go && bus_rd && (par_hit | mmr0_hit);
   assign pxr_wr      = go && bus_wr && (par_hit | mmr0_hit);
   assign pxr_addr    = mmr0_hit ? 4'd8 : {1'b0, cpu_pa[3:1]};
   assign pxr_data_in = wdata_lane;
   assign reg_word    = swr_hit ? switches : pxr_data_out;

   // ------------------------------
   // request sequencing
   always_ff @(posedge sysclk)
   begin
      if (!rst_n)
      begin
         state  <= st_idle;
         err_q  <= 1'b0;
         ram_we <= 1'b0;
      end
      else
      begin
         ram_we <= 1'b0;
         case (state)
            st_idle:
               if (strobe)
               begin
                  err_q <= !(ram_hit | reg_hit);
                  if (ram_hit)
                  begin
                     ram_we <= bus_wr;
                     state  <= st_ram_wait;
                  end
                  else
                     state <= st_respond;
               end
            st_ram_wait:
               state <= st_respond;
            st_respond:
               state <= st_done;
            // a held strobe is ignored until seen low
            default:
               if (!strobe)
                  state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge sysclk)
   begin
      if (go)
      begin
         ram_src_q <= ram_hit;
         is_byte_q <= bus_byte_op;
         odd_q     <= cpu_pa[0];
         rdata_q   <= steer_rd(reg_word, bus_byte_op, cpu_pa[0]);
         ram_addr  <= cpu_pa[ram_aw:1];
         ram_wdata <= wdata_lane;
         ram_be    <= be;
      end
   end

   // display register, written per lane
   always_ff @(posedge sysclk)
   begin
      if (!rst_n || soft_reset)
         disp_q <= '0;
      else if (go && bus_wr && swr_hit)
      begin
         if (be[0])
            disp_q[7:0] <= wdata_lane[7:0];
         if (be[1])
            disp_q[15:8] <= wdata_lane[15:8];
      end
   end

   assign disp_value   = disp_q;
   assign bus_ack      = (state == st_respond) && !err_q;
   assign bus_error    = (state == st_respond) && err_q;
   assign bus_data_out = ram_src_q ? steer_rd(ram_rdata, is_byte_q, odd_q) : rdata_q;

endmodule

//--- hw/ram_sync.sv
/*
   On-chip word RAM with upper and lower byte enables.
   Read data appears one cycle after the address.
*/
module ram_sync
   import pdp_pkg::*;
#(
   parameter int ram_words = 4096
) (
   input  logic                         sysclk,
   input  logic [$clog2(ram_words)-1:0] ram_addr,
   input  logic [word_w-1:0]            ram_wdata,
   input  logic [1:0]                   ram_be,
   input  logic                         ram_we,
   output logic [word_w-1:0]            ram_rdata
);

   logic [word_w-1:0] mem [0:ram_words-1];

   always_ff @(posedge sysclk)
   begin
      if (ram_we)
      begin
         if (ram_be[0])
            mem[ram_addr][7:0] <= ram_wdata[7:0];
         if (ram_be[1])
            mem[ram_addr][15:8] <= ram_wdata[15:8];
      end
   end

   // old data on a same-cycle write
   always_ff @(posedge sysclk)
   begin
      ram_rdata <= mem[ram_addr];
   end

endmodule

//--- hw/display.sv
/*
   Four-digit seven-segment driver for the display register.
   Anodes and segments are active low, the dot stays off.
*/
module display
   import pdp_pkg::*;
#(
   parameter int scan_cycles = 4
) (
   input  logic              sysclk,
   input  logic              rst_n,
   input  logic [word_w-1:0] disp_value,
   output logic [7:0]        sevenseg,
   output logic [3:0]        sevenseg_an
);

   localparam int div_w = $clog2(scan_cycles + 1);

   logic [div_w-1:0] div;
   logic [1:0]       digit;
   logic [3:0]       nibble;
   logic [6:0]       seg;

   always_ff @(posedge sysclk)
   begin
      if (!rst_n)
      begin
         div   <= '0;
         digit <= '0;
      end
      else if (div == div_w'(scan_cycles - 1))
      begin
         div   <= '0;
         digit <= digit + 1'b1;
      end
      else
         div <= div + 1'b1;
   end

   assign nibble = disp_value[digit*4 +: 4];

   // segments g..a
   always_comb
   begin
      case (nibble)
         4'h0: seg = 7'h40;
         4'h1: seg = 7'h79;
         4'h2: seg = 7'h24;
         4'h3: seg = 7'h30;
         4'h4: seg = 7'h19;
         4'h5: seg = 7'h12;
         4'h6: seg = 7'h02;
         4'h7: seg = 7'h78;
         4'h8: seg = 7'h00;
         4'h9: seg = 7'h10;
         4'ha: seg = 7'h08;
         4'hb: seg = 7'h03;
         4'hc: seg = 7'h46;
         4'hd: seg = 7'h21;
         4'he: seg = 7'h06;
         default: seg = 7'h0e;
      endcase
   end

   assign sevenseg    = {1'b1, seg};
   assign sevenseg_an = ~(4'b0001 << digit);

endmodule

//--- hw/pdp_mem_top.sv
/*
   Memory side of the PDP-11 board. The processor bus is exposed as
   ports; the MMU, bus, RAM, reset button and display sit behind it.
*/
module pdp_mem_top
   import pdp_pkg::*;
#(
   parameter int ram_words       = 4096,
   parameter int debounce_cycles = 16,
   parameter int scan_cycles     = 4
) (
   input  logic              sysclk,
   input  logic              rst_n,
   input  logic              button,
   input  logic [word_w-1:0] switches,
   input  logic [va_w-1:0]   bus_addr,
   input  logic [word_w-1:0] bus_data_in,
   output logic [word_w-1:0] bus_data_out,
   input  logic              bus_rd,
   input  logic              bus_wr,
   input  logic              bus_byte_op,
   output logic              bus_ack,
   output logic              bus_error,
   output logic [7:0]        sevenseg,
   output logic [3:0]        sevenseg_an
);

   localparam int ram_aw = $clog2(ram_words);

   logic              soft_reset;
   logic [pa_w-1:0]   cpu_pa;
   logic              pxr_wr;
   logic              pxr_rd;
   logic [3:0]        pxr_addr;
   logic [word_w-1:0] pxr_data_in;
   logic [word_w-1:0] pxr_data_out;
   logic [ram_aw-1:0] ram_addr;
   logic [word_w-1:0] ram_wdata;
   logic [1:0]        ram_be;
   logic              ram_we;
   logic [word_w-1:0] ram_rdata;
   logic [word_w-1:0] disp_value;

   reset_btn #(.debounce_cycles(debounce_cycles)) reset_btn0 (
      .sysclk(sysclk), .rst_n(rst_n), .button(button), .soft_reset(soft_reset)
   );

   mmu mmu0 (
      .sysclk(sysclk), .rst_n(rst_n), .soft_reset(soft_reset),
      .cpu_va(bus_addr), .cpu_pa(cpu_pa),
      .pxr_wr(pxr_wr), .pxr_rd(pxr_rd), .pxr_addr(pxr_addr),
      .pxr_data_in(pxr_data_in), .pxr_data_out(pxr_data_out)
   );

   bus #(.ram_words(ram_words)) bus0 (
      .sysclk(sysclk), .rst_n(rst_n), .soft_reset(soft_reset),
      .cpu_pa(cpu_pa), .bus_data_in(bus_data_in), .bus_data_out(bus_data_out),
      .bus_rd(bus_rd), .bus_wr(bus_wr), .bus_byte_op(bus_byte_op),
      .bus_ack(bus_ack), .bus_error(bus_error), .switches(switches),
      .pxr_wr(pxr_wr), .pxr_rd(pxr_rd), .pxr_addr(pxr_addr),
      .pxr_data_in(pxr_data_in), .pxr_data_out(pxr_data_out),
      .ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_be(ram_be),
      .ram_we(ram_we), .ram_rdata(ram_rdata), .disp_value(disp_value)
   );

   ram_sync #(.ram_words(ram_words)) ram0 (
      .sysclk(sysclk), .ram_addr(ram_addr), .ram_wdata(ram_wdata),
      .ram_be(ram_be), .ram_we(ram_we), .ram_rdata(ram_rdata)
   );

   display #(.scan_cycles(scan_cycles)) display0 (
      .sysclk(sysclk), .rst_n(rst_n), .disp_value(disp_value),
      .sevenseg(sevenseg), .sevenseg_an(sevenseg_an)
   );

endmodule

//--- tb/pdp_mem_chk.sv
/*
   Handshake checks on the processor bus, bound into the bus module.
   Covers reply exclusivity, pulse width, strobe presence and latency.
*/
module pdp_mem_chk (
   input logic sysclk,
   input logic rst_n,
   input logic bus_rd,
   input logic bus_wr,
   input logic bus_ack,
   input logic bus_error,
   input logic go,
   input logic ram_hit
);

   timeunit 1ns;
   timeprecision 1ps;

   int viol_count = 0;

   // ------------------------------
   // reply shape
   reply_exclusive: assert property (@(posedge sysclk) disable iff (!rst_n)
      !(bus_ack && bus_error))
   else
   begin
      viol_count++;
      $error("ack and error high in the same cycle");
   end

   reply_pulse: assert property (@(posedge sysclk) disable iff (!rst_n)
      (bus_ack || bus_error) |=> !(bus_ack || bus_error))
   else
   begin
      viol_count++;
      $error("reply held longer than one cycle");
   end

   reply_needs_strobe: assert property (@(posedge sysclk) disable iff (!rst_n)
      (bus_ack || bus_error) |-> (bus_rd || bus_wr))
   else
   begin
      viol_count++;
      $error("reply without a read or write strobe");
   end

   // ------------------------------
   // latency
   reg_latency: assert property (@(posedge sysclk) disable iff (!rst_n)
      (go && !ram_hit) |=> (bus_ack || bus_error))
   else
   begin
      viol_count++;
      $error("register or error reply not one cycle after request");
   end

   ram_gap: assert property (@(posedge sysclk) disable iff (!rst_n)
      (go && ram_hit) |=> !(bus_ack || bus_error))
   else
   begin
      viol_count++;
      $error("RAM reply came too early");
   end

   ram_latency: assert property (@(posedge sysclk) disable iff (!rst_n)
      $past(go && ram_hit, 2) |-> bus_ack)
   else
   begin
      viol_count++;
      $error("RAM ack not two cycles after request");
   end

endmodule

bind bus pdp_mem_chk chk0 (
   .sysclk(sysclk), .rst_n(rst_n), .bus_rd(bus_rd), .bus_wr(bus_wr),
   .bus_ack(bus_ack), .bus_error(bus_error), .go(go), .ram_hit(ram_hit)
);

//--- tb/pdp_mem_tb.sv
/*
   Testbench for the PDP-11 memory subsystem. Plays the processor on the
   bus, runs a table of transactions predicted by a reference model, and
   checks the seven-segment scan and the reset button.
*/
module pdp_mem_tb
   import pdp_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int ram_words       = 4096;
   localparam int debounce_cycles = 16;
   localparam int scan_cycles     = 4;
   localparam int table_len       = 47;
   localparam int cycle_limit     = table_len * 10 + 2 * 8 * scan_cycles
                                    + 2 * debounce_cycles + 200;
   localparam logic [15:0] switch_value = 16'h5a3c;

   typedef struct {
      logic        is_wr;
      logic        is_byte;
      logic [15:0] va;
      logic [15:0] wdata;
      logic [15:0] exp_data;
      logic        exp_err;
   } entry_t;

   logic              sysclk;
   logic              rst_n;
   logic              button;
   logic [word_w-1:0] switches;
   logic [va_w-1:0]   bus_addr;
   logic [word_w-1:0] bus_data_in;
   logic [word_w-1:0] bus_data_out;
   logic              bus_rd;
   logic              bus_wr;
   logic              bus_byte_op;
   logic              bus_ack;
   logic              bus_error;
   logic [7:0]        sevenseg;
   logic [3:0]        sevenseg_an;

   entry_t      tbl [$];
   logic [15:0] ref_mem [0:ram_words-1];
   logic [11:0] ref_par [0:7];
   logic        ref_en;
   logic [15:0] ref_disp;
   int          seed   = 32'h2536;
   int          errors = 0;
   int          cycles = 0;

   pdp_mem_top #(
      .ram_words(ram_words), .debounce_cycles(debounce_cycles), .scan_cycles(scan_cycles)
   ) dut0 (
      .sysclk(sysclk), .rst_n(rst_n), .button(button), .switches(switches),
      .bus_addr(bus_addr), .bus_data_in(bus_data_in), .bus_data_out(bus_data_out),
      .bus_rd(bus_rd), .bus_wr(bus_wr), .bus_byte_op(bus_byte_op),
      .bus_ack(bus_ack), .bus_error(bus_error),
      .sevenseg(sevenseg), .sevenseg_an(sevenseg_an)
   );

   initial
   begin
      sysclk = 1'b0;
      forever #20 sysclk = ~sysclk;
   end

   always @(posedge sysclk)
   begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit)
      begin
         $display("Timeout: run did not finish within %0d cycles", cycle_limit);
         $display("Test failed");
         $finish;
      end
   end

   // ------------------------------
   // reference model
   function automatic logic [17:0] model_pa(input logic [15:0] va);
      logic [17:0] base;
      base = {ref_par[va[15:13]], 6'b000000};
      if (ref_en)
         return base + {5'b00000, va[12:0]};
      if (va >= 16'o160000)
         return {2'b00, va} + 18'o600000;
      return {2'b00, va};
   endfunction

   // active-high gfedcba
   function automatic logic [6:0] seg_shape(input logic [3:0] d);
      case (d)
         4'h0: return 7'h3f;
         4'h1: return 7'h06;
         4'h2: return 7'h5b;
         4'h3: return 7'h4f;
         4'h4: return 7'h66;
         4'h5: return 7'h6d;
         4'h6: return 7'h7d;
         4'h7: return 7'h07;
         4'h8: return 7'h7f;
         4'h9: return 7'h6f;
         4'ha: return 7'h77;
         4'hb: return 7'h7c;
         4'hc: return 7'h39;
         4'hd: return 7'h5e;
         4'he: return 7'h79;
         default: return 7'h71;
      endcase
   endfunction

   // predicts the reply and updates the model before queuing the entry
   task automatic add_entry(input logic is_wr, input logic is_byte,
                            input logic [15:0] va, input logic [15:0] wdata);
      entry_t      e;
      logic [17:0] pa;
      int          w;
      pa         = model_pa(va);
      w          = int'(pa[17:1]);
      e.is_wr    = is_wr;
      e.is_byte  = is_byte;
      e.va       = va;
      e.wdata    = wdata;
      e.exp_data = 16'h0000;
      e.exp_err  = 1'b0;
      if (!is_byte && pa[0])
         e.exp_err = 1'b1;
      else if (pa < 18'(ram_words * 2))
      begin
         if (is_wr && is_byte && pa[0])
            ref_mem[w][15:8] = wdata[7:0];
         else if (is_wr && is_byte)
            ref_mem[w][7:0] = wdata[7:0];
         else if (is_wr)
            ref_mem[w] = wdata;
         else if (is_byte)
            e.exp_data = (ref_mem[w] >> (pa[0] ? 8 : 0)) & 16'h00ff;
         else
            e.exp_data = ref_mem[w];
      end
      else if (pa[17:4] == par_base[17:4])
      begin
         if (is_wr)
            ref_par[pa[3:1]] = wdata[11:0];
         else
            e.exp_data = {4'h0, ref_par[pa[3:1]]};
      end
      else if (pa[17:1] == mmr0_addr[17:1])
      begin
         if (is_wr)
            ref_en = wdata[0];
         else
            e.exp_data = {15'h0000, ref_en};
      end
      else if (pa[17:1] == swr_addr[17:1])
      begin
         if (is_wr)
            ref_disp = wdata;
         else
            e.exp_data = switch_value;
      end
      else
         e.exp_err = 1'b1;
      tbl.push_back(e);
   endtask

   // ------------------------------
   // bus master
   task automatic run_request(input entry_t e);
      logic [15:0] got;
      logic        ack;
      logic        err;
      @(posedge sysclk);
      bus_addr    <= e.va;
      bus_data_in <= e.wdata;
      bus_byte_op <= e.is_byte;
      bus_rd      <= !e.is_wr;
      bus_wr      <= e.is_wr;
      // strobe stays up until ack or error
      do
         @(negedge sysclk);
      while (!(bus_ack || bus_error));
      got = bus_data_out;
      ack = bus_ack;
      err = bus_error;
      @(posedge sysclk);
      bus_rd <= 1'b0;
      bus_wr <= 1'b0;
      assert (err == e.exp_err && ack == !e.exp_err)
      else
      begin
         errors++;
         $display("MISMATCH at %0d ns: va %o expected error %0b, got ack %0b error %0b",
                  $time, e.va, e.exp_err, ack, err);
      end
      if (!e.is_wr && !e.exp_err)
      begin
         assert (got == e.exp_data)
         else
         begin
            errors++;
            $display("MISMATCH at %0d ns: read of va %o returned %h, expected %h",
                     $time, e.va, got, e.exp_data);
         end
      end
   endtask

   task automatic run_table();
      foreach (tbl[i])
         run_request(tbl[i]);
      tbl.delete();
   endtask

   // one full scan with every digit checked at its anode
   task automatic check_scan(input logic [15:0] value);
      logic [3:0] seen;
      logic [7:0] exp_seg;
      int         idx;
      seen = 4'b0000;
      repeat (4 * scan_cycles)
      begin
         @(negedge sysclk);
         case (sevenseg_an)
            4'b1110: idx = 0;
            4'b1101: idx = 1;
            4'b1011: idx = 2;
            4'b0111: idx = 3;
            default: idx = -1;
         endcase
         assert (idx >= 0)
         else
         begin
            errors++;
            $display("MISMATCH at %0d ns: anodes %b select no single digit", $time, sevenseg_an);
         end
         if (idx >= 0)
         begin
            seen[idx] = 1'b1;
            exp_seg   = {1'b1, ~seg_shape(value[idx*4 +: 4])};
            assert (sevenseg == exp_seg)
            else
            begin
               errors++;
               $display("MISMATCH at %0d ns: digit %0d shows %h, expected %h",
                        $time, idx, sevenseg, exp_seg);
            end
         end
      end
      assert (seen == 4'hf)
      else
      begin
         errors++;
         $display("Display scan did not reach all four digits (seen %b)", seen);
      end
   endtask

   task automatic press_button();
      @(posedge sysclk);
      button <= 1'b1;
      repeat (debounce_cycles + 2) @(posedge sysclk);
      button <= 1'b0;
   endtask

   // ------------------------------
   // transaction tables
   task automatic load_bus_tests();
      for (int i = 0; i < 8; i++)
         add_entry(1'b1, 1'b0, 16'(16'o001000 + i * 16'o202), 16'($random(seed)));
      for (int i = 0; i < 8; i++)
         add_entry(1'b0, 1'b0, 16'(16'o001000 + i * 16'o202), 16'h0000);
      // byte lanes
      add_entry(1'b1, 1'b1, 16'o002001, 16'($random(seed)));
      add_entry(1'b1, 1'b1, 16'o002000, 16'($random(seed)));
      add_entry(1'b0, 1'b0, 16'o002000, 16'h0000);
      add_entry(1'b0, 1'b1, 16'o002000, 16'h0000);
      add_entry(1'b0, 1'b1, 16'o002001, 16'h0000);
      // odd word, hole below the I/O page, unused I/O address
      add_entry(1'b1, 1'b0, 16'o002003, 16'h1234);
      add_entry(1'b0, 1'b0, 16'o002005, 16'h0000);
      add_entry(1'b0, 1'b0, 16'o140000, 16'h0000);
      add_entry(1'b0, 1'b0, 16'o177000, 16'h0000);
      add_entry(1'b0, 1'b0, 16'o177570, 16'h0000);
      add_entry(1'b1, 1'b0, 16'o177570, 16'hbe7a);
      // pages 1 and 2 share one block while page 7 stays on the I/O page
      add_entry(1'b1, 1'b0, 16'o172342, 16'o000100);
      add_entry(1'b1, 1'b0, 16'o172344, 16'o000100);
      add_entry(1'b1, 1'b0, 16'o172356, 16'o007600);
      add_entry(1'b0, 1'b0, 16'o172342, 16'h0000);
      add_entry(1'b0, 1'b0, 16'o172344, 16'h0000);
      add_entry(1'b0, 1'b0, 16'o172356, 16'h0000);
      add_entry(1'b1, 1'b0, 16'o177572, 16'h0001);
      add_entry(1'b0, 1'b0, 16'o177572, 16'h0000);
      add_entry(1'b1, 1'b0, 16'o020010, 16'($random(seed)));
      add_entry(1'b1, 1'b0, 16'o020012, 16'($random(seed)));
      add_entry(1'b0, 1'b0, 16'o040010, 16'h0000);
      add_entry(1'b1, 1'b1, 16'o040013, 16'($random(seed)));
      add_entry(1'b0, 1'b1, 16'o020013, 16'h0000);
      add_entry(1'b0, 1'b0, 16'o020012, 16'h0000);
   endtask

   task automatic load_reset_tests();
      add_entry(1'b0, 1'b0, 16'o172342, 16'h0000);
      add_entry(1'b0, 1'b0, 16'o172344, 16'h0000);
      add_entry(1'b0, 1'b0, 16'o172356, 16'h0000);
      add_entry(1'b0, 1'b0, 16'o177572, 16'h0000);
      // RAM survives the button
      add_entry(1'b0, 1'b0, 16'o010010, 16'h0000);
      add_entry(1'b0, 1'b0, 16'o001000, 16'h0000);
   endtask

   // ------------------------------
   // main sequence
   initial
   begin
      rst_n       = 1'b0;
      button      = 1'b0;
      switches    = switch_value;
      bus_addr    = '0;
      bus_data_in = '0;
      bus_rd      = 1'b0;
      bus_wr      = 1'b0;
      bus_byte_op = 1'b0;
      ref_en      = 1'b0;
      ref_disp    = 16'h0000;
      for (int i = 0; i < 8; i++)
         ref_par[i] = 12'h000;
      repeat (4) @(posedge sysclk);
      rst_n <= 1'b1;

      load_bus_tests();
      run_table();
      check_scan(ref_disp);

      press_button();
      ref_en   = 1'b0;
      ref_disp = 16'h0000;
      for (int i = 0; i < 8; i++)
         ref_par[i] = 12'h000;
      load_reset_tests();
      run_table();
      check_scan(ref_disp);

      $display("Checks done: %0d errors, %0d assertion failures",
               errors, dut0.bus0.chk0.viol_count);
      if (errors == 0 && dut0.bus0.chk0.viol_count == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

//--- pdp_mem_top.f
hw/pdp_pkg.sv
hw/reset_btn.sv
hw/mmu.sv
hw/bus.sv
hw/ram_sync.sv
hw/display.sv
hw/pdp_mem_top.sv
tb/pdp_mem_chk.sv
tb/pdp_mem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal \
   --top-module pdp_mem_tb -f pdp_mem_top.f -Mdir obj_dir \
   && ./obj_dir/Vpdp_mem_tb +verilator+error+limit+1000 > sim.log 2>&1 \
   || echo "build or simulation ended with an error"
cat sim.log 2>/dev/null
grep -q "Test completed successfully" sim.log 2>/dev/null && exit 0 || exit 1
